/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module dsp_backend_tb -Mdir obj_dir -o sim \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed."; exit 1; }
cat sim.log
grep -q "^ALL TESTS PASSED$" sim.log \
	&& echo "Simulation passed." \
	|| { echo "Simulation failed."; exit 1; }

/* src.f */
+incdir+src
src/dsp_pkg.sv
src/dsp_cfg_regs.sv
src/ffe_stage.sv
src/slicer_stage.sv
src/mlsd_check_stage.sv
src/dsp_backend.sv
verification/dsp_backend_tb.sv

/* src/dsp_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module dsp_backend (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::code_word_t codes_i,
	input wire logic cfg_req_i,
	input wire dsp_pkg::cfg_req_t cfg_i,
	output logic cfg_ack_o,
	output dsp_pkg::code_word_t est_o,
	output dsp_pkg::bit_word_t checked_o
);
	dsp_pkg::dsp_coefs_t coefs;
	dsp_pkg::eq_word_t eq_word;
	dsp_pkg::slice_word_t slice_word;

	dsp_cfg_regs u_cfg_regs (
		.clk(clk),
		.rstb(rstb),
		.cfg_req_i(cfg_req_i),
		.cfg_i(cfg_i),
		.cfg_ack_o(cfg_ack_o),
		.coefs_o(coefs)
	);

	ffe_stage u_ffe (
		.clk(clk),
		.rstb(rstb),
		.codes_i(codes_i),
		.coefs_i(coefs),
		.eq_o(eq_word)
	);

	slicer_stage u_slicer (
		.clk(clk),
		.rstb(rstb),
		.eq_i(eq_word),
		.coefs_i(coefs),
		.slice_o(slice_word)
	);

	mlsd_check_stage u_mlsd (
		.clk(clk),
		.rstb(rstb),
		.slice_i(slice_word),
		.coefs_i(coefs),
		.checked_o(checked_o)
	);

	assign est_o = eq_word.eq;

endmodule : dsp_backend

`default_nettype wire

/* src/dsp_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dsp_macros.svh"

module dsp_cfg_regs (
	input wire logic clk,
	input wire logic rstb,
	input wire logic cfg_req_i,
	input wire dsp_pkg::cfg_req_t cfg_i,
	output logic cfg_ack_o,
	output dsp_pkg::dsp_coefs_t coefs_o
);
	localparam int ADDR_W = `DSP_CFG_ADDR_W;
	localparam int LANES = `DSP_LANES;

	logic wr_en;
	logic in_weight;
	logic in_thresh;
	logic in_est;
	logic in_shift;
	logic [ADDR_W-1:0] offset;

	// New request only while ack is low.
	assign wr_en = cfg_req_i && !cfg_ack_o;

	always_comb begin
		in_weight = cfg_i.addr < ADDR_W'(`DSP_ADDR_THRESH);
		in_thresh = !in_weight && (cfg_i.addr < ADDR_W'(`DSP_ADDR_EST));
		in_est = !in_weight && !in_thresh && (cfg_i.addr < ADDR_W'(`DSP_ADDR_SHIFT));
		in_shift = cfg_i.addr == ADDR_W'(`DSP_ADDR_SHIFT);
		if (in_thresh) begin
			offset = cfg_i.addr - ADDR_W'(`DSP_ADDR_THRESH);
		end else if (in_est) begin
			offset = cfg_i.addr - ADDR_W'(`DSP_ADDR_EST);
		end else begin
			offset = cfg_i.addr - ADDR_W'(`DSP_ADDR_WEIGHT);
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cfg_ack_o <= 1'b0;
		end else if (wr_en) begin
			cfg_ack_o <= 1'b1;
		end else if (!cfg_req_i) begin
			cfg_ack_o <= 1'b0;
		end
	end

	// Addresses past the shift word fall in no region.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			coefs_o <= '0;
		end else if (wr_en) begin
			for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
				for (int l = 0; l < LANES; l++) begin
					if (in_weight && offset == ADDR_W'(t * LANES + l)) begin
						coefs_o.weight[t][l] <= cfg_i.data.coef.value;
					end
				end
			end
			for (int l = 0; l < LANES; l++) begin
				if (in_thresh && offset == ADDR_W'(l)) begin
					coefs_o.thresh[l] <= cfg_i.data.coef.value;
				end
			end
			for (int t = 0; t < `DSP_EST_DEPTH; t++) begin
				for (int l = 0; l < LANES; l++) begin
					if (in_est && offset == ADDR_W'(t * LANES + l)) begin
						coefs_o.est[t][l] <= cfg_i.data.coef.value;
					end
				end
			end
			if (in_shift) begin
				coefs_o.ffe_shift <= cfg_i.data.shift.ffe_shift;
				coefs_o.mlsd_shift <= cfg_i.data.shift.mlsd_shift;
			end
		end
	end

endmodule : dsp_cfg_regs

`default_nettype wire

/* src/dsp_macros.svh */
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// Lane count and data widths.
`define DSP_LANES 4
`define DSP_CODE_W 8
`define DSP_COEF_W 8

// Tap counts.
`define DSP_FFE_TAPS 3
`define DSP_EST_DEPTH 3

`define DSP_SHIFT_W 4

// Configuration port.
`define DSP_CFG_ADDR_W 5
`define DSP_CFG_DATA_W 16

// Register map base addresses.
`define DSP_ADDR_WEIGHT 0
`define DSP_ADDR_THRESH 12
`define DSP_ADDR_EST 16
`define DSP_ADDR_SHIFT 28

`endif

/* src/dsp_pkg.sv */
`default_nettype none
`include "dsp_macros.svh"

package dsp_pkg;

	typedef logic signed [`DSP_CODE_W-1:0] code_t;
	typedef logic signed [`DSP_COEF_W-1:0] coef_t;

	// Lane 0 is the earliest symbol.
	typedef code_t [`DSP_LANES-1:0] code_word_t;
	typedef logic [`DSP_LANES-1:0] bit_word_t;

	// Same word, read as a coefficient or as the shift pair.
	typedef union packed {
		struct packed {
			logic [`DSP_CFG_DATA_W-`DSP_COEF_W-1:0] rsvd;
			coef_t value;
		} coef;
		struct packed {
			logic [`DSP_SHIFT_W-1:0] ffe_shift;
			logic [`DSP_SHIFT_W-1:0] mlsd_shift;
			logic [`DSP_CFG_DATA_W-2*`DSP_SHIFT_W-1:0] rsvd;
		} shift;
	} cfg_word_u;

	typedef struct packed {
		logic [`DSP_CFG_ADDR_W-1:0] addr;
		cfg_word_u data;
	} cfg_req_t;

	typedef struct packed {
		coef_t [`DSP_FFE_TAPS-1:0][`DSP_LANES-1:0] weight;
		coef_t [`DSP_LANES-1:0] thresh;
		coef_t [`DSP_EST_DEPTH-1:0][`DSP_LANES-1:0] est;
		logic [`DSP_SHIFT_W-1:0] ffe_shift;
		logic [`DSP_SHIFT_W-1:0] mlsd_shift;
	} dsp_coefs_t;

	typedef struct packed {
		code_word_t codes;
		code_word_t eq;
	} eq_word_t;

	typedef struct packed {
		code_word_t codes;
		bit_word_t bits;
	} slice_word_t;

endpackage : dsp_pkg

`default_nettype wire

/* src/ffe_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dsp_macros.svh"

module ffe_stage (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::code_word_t codes_i,
	input wire dsp_pkg::dsp_coefs_t coefs_i,
	output dsp_pkg::eq_word_t eq_o
);
	localparam int LANES = `DSP_LANES;
	localparam int TAPS = `DSP_FFE_TAPS;
	localparam int CODE_W = `DSP_CODE_W;
	localparam int ACC_W = CODE_W + `DSP_COEF_W + $clog2(TAPS) + 1;
	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((1 << (CODE_W - 1)) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - 1;

	dsp_pkg::code_t [2*LANES-1:0] window;
	dsp_pkg::code_word_t eq_next;

	// Registered codes double as the past-word buffer.
	assign window = {codes_i, eq_o.codes};

	always_comb begin
		logic signed [ACC_W-1:0] acc;
		logic signed [ACC_W-1:0] shifted;
		for (int l = 0; l < LANES; l++) begin
			acc = '0;
			// Tap k reaches k symbols back, possibly into the prior word.
			for (int k = 0; k < TAPS; k++) begin
				acc = acc + coefs_i.weight[k][l] * window[LANES + l - k];
			end
			shifted = acc >>> coefs_i.ffe_shift;
			if (shifted > SAT_MAX) begin
				eq_next[l] = SAT_MAX[CODE_W-1:0];
			end else if (shifted < SAT_MIN) begin
				eq_next[l] = SAT_MIN[CODE_W-1:0];
			end else begin
				eq_next[l] = shifted[CODE_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			eq_o <= '0;
		end else begin
			eq_o.codes <= codes_i;
			eq_o.eq <= eq_next;
		end
	end

endmodule : ffe_stage

`default_nettype wire

/* src/mlsd_check_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dsp_macros.svh"

module mlsd_check_stage (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::slice_word_t slice_i,
	input wire dsp_pkg::dsp_coefs_t coefs_i,
	output dsp_pkg::bit_word_t checked_o
);
	localparam int LANES = `DSP_LANES;
	localparam int DEPTH = `DSP_EST_DEPTH;
	localparam int ACC_W = `DSP_COEF_W + $clog2(DEPTH) + 1;
	localparam int ERR_W = ACC_W + 1;

	dsp_pkg::bit_word_t prev_bits;
	dsp_pkg::bit_word_t final_bits;
	logic [2*LANES-1:0] bit_window;

	assign bit_window = {slice_i.bits, prev_bits};

	function automatic logic [ERR_W-1:0] abs_err(input logic signed [ERR_W-1:0] diff);
		if (diff < 0) begin
			return -diff;
		end
		return diff;
	endfunction

	always_comb begin
		logic signed [ACC_W-1:0] past;
		logic signed [ACC_W-1:0] pred_one;
		logic signed [ACC_W-1:0] pred_zero;
		logic [ERR_W-1:0] err_one;
		logic [ERR_W-1:0] err_zero;
		logic raw;
		for (int l = 0; l < LANES; l++) begin
			// Contribution of earlier raw decisions, a one counts +1 and a zero -1.
			past = '0;
			for (int k = 1; k < DEPTH; k++) begin
				if (bit_window[LANES + l - k]) begin
					past = past + coefs_i.est[k][l];
				end else begin
					past = past - coefs_i.est[k][l];
				end
			end

			// Both hypotheses for the current symbol.
			pred_one = (past + coefs_i.est[0][l]) >>> coefs_i.mlsd_shift;
			pred_zero = (past - coefs_i.est[0][l]) >>> coefs_i.mlsd_shift;
			err_one = abs_err(slice_i.codes[l] - pred_one);
			err_zero = abs_err(slice_i.codes[l] - pred_zero);

			// Flip only on a strictly better fit.
			raw = slice_i.bits[l];
			if (raw) begin
				final_bits[l] = !(err_zero < err_one);
			end else begin
				final_bits[l] = err_one < err_zero;
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			prev_bits <= '0;
			checked_o <= '0;
		end else begin
			prev_bits <= slice_i.bits;
			checked_o <= final_bits;
		end
	end

endmodule : mlsd_check_stage

`default_nettype wire

/* src/slicer_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dsp_macros.svh"

module slicer_stage (
	input wire logic clk,
	input wire logic rstb,
	input wire dsp_pkg::eq_word_t eq_i,
	input wire dsp_pkg::dsp_coefs_t coefs_i,
	output dsp_pkg::slice_word_t slice_o
);
	dsp_pkg::bit_word_t raw_bits;

	// Signed compare, ties go to one.
	always_comb begin
		for (int l = 0; l < `DSP_LANES; l++) begin
			raw_bits[l] = eq_i.eq[l] >= coefs_i.thresh[l];
		end
	end

	// Codes ride along so the checker sees them aligned with their bits.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			slice_o <= '0;
		end else begin
			slice_o.codes <= eq_i.codes;
			slice_o.bits <= raw_bits;
		end
	end

endmodule : slicer_stage

`default_nettype wire

/* verification/dsp_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dsp_macros.svh"

module dsp_backend_tb;
	localparam int LANES = `DSP_LANES;
	localparam int WORDS = 300;
	// Six streaming phases plus a budget for about 70 writes.
	localparam int MAX_CYCLES = 6 * WORDS + 2200;

	logic clk;
	logic rstb;
	dsp_pkg::code_word_t codes_i;
	logic cfg_req_i;
	dsp_pkg::cfg_req_t cfg_i;
	logic cfg_ack_o;
	dsp_pkg::code_word_t est_o;
	dsp_pkg::bit_word_t checked_o;

	logic [31:0] lfsr = 32'h827b_caeb;
	string test_name = "reset";
	int err_est = 0;
	int err_chk = 0;
	int err_ack = 0;
	int err_misc = 0;
	int sat_hi = 0;
	int sat_lo = 0;
	int flips = 0;
	int cycles = 0;
	logic [3:0] ffe_sh;

	// Reference model state, one register per pipeline stage.
	dsp_pkg::dsp_coefs_t mc;
	logic m_ack;
	dsp_pkg::code_word_t m_codes;
	dsp_pkg::code_word_t m_eq;
	dsp_pkg::code_word_t m_sl_codes;
	dsp_pkg::bit_word_t m_sl_bits;
	dsp_pkg::bit_word_t m_prev_bits;
	dsp_pkg::bit_word_t m_chk;

	dsp_backend u_dut (
		.clk(clk),
		.rstb(rstb),
		.codes_i(codes_i),
		.cfg_req_i(cfg_req_i),
		.cfg_i(cfg_i),
		.cfg_ack_o(cfg_ack_o),
		.est_o(est_o),
		.checked_o(checked_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois LFSR, one step per bit.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return bits;
	endfunction

	function automatic int sign_ext(input logic [7:0] v);
		return int'($signed(v));
	endfunction

	function automatic void record_write(input dsp_pkg::cfg_req_t req);
		int a;
		int e;
		a = int'(req.addr);
		e = a - `DSP_ADDR_EST;
		if (a < `DSP_ADDR_THRESH) begin
			mc.weight[a / LANES][a % LANES] = req.data.coef.value;
		end else if (a < `DSP_ADDR_EST) begin
			mc.thresh[a - `DSP_ADDR_THRESH] = req.data.coef.value;
		end else if (a < `DSP_ADDR_SHIFT) begin
			mc.est[e / LANES][e % LANES] = req.data.coef.value;
		end else if (a == `DSP_ADDR_SHIFT) begin
			mc.ffe_shift = req.data.shift.ffe_shift;
			mc.mlsd_shift = req.data.shift.mlsd_shift;
		end
	endfunction

	// One clock, with a fresh code word.
	task automatic tick();
		@(posedge clk);
		codes_i <= take_bits(32);
	endtask

	task automatic cfg_write(input logic [4:0] addr, input logic [15:0] data);
		int waited;
		repeat (take_bits(2)) tick();
		cfg_req_i <= 1'b1;
		cfg_i <= {addr, data};
		waited = 0;
		do begin
			tick();
			waited++;
		end while (!cfg_ack_o && waited <= 4);
		if (!cfg_ack_o) begin
			err_misc++;
			$display("%s: ack did not rise within 4 cycles of req at address %0d",
				test_name, addr);
		end
		cfg_req_i <= 1'b0;
		waited = 0;
		do begin
			tick();
			waited++;
		end while (cfg_ack_o && waited <= 4);
		if (cfg_ack_o) begin
			err_misc++;
			$display("%s: ack stayed high more than 4 cycles after req fell", test_name);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin : model_step
		int acc;
		int past;
		int pred_one;
		int pred_zero;
		int err_one;
		int err_zero;
		int win [2*LANES];
		logic bwin [2*LANES];
		dsp_pkg::code_word_t nxt_eq;
		dsp_pkg::bit_word_t nxt_raw;
		dsp_pkg::bit_word_t nxt_chk;
		if (!rstb) begin
			mc = '0;
			m_ack = 1'b0;
			m_codes = '0;
			m_eq = '0;
			m_sl_codes = '0;
			m_sl_bits = '0;
			m_prev_bits = '0;
			m_chk = '0;
		end else begin
			if (est_o !== m_eq) begin
				err_est++;
				$display("[ERROR] %s: est_o expected %h actual %h",
					test_name, m_eq, est_o);
			end
			if (checked_o !== m_chk) begin
				err_chk++;
				$display("[ERROR] %s: checked_o expected %b actual %b",
					test_name, m_chk, checked_o);
			end
			if (cfg_ack_o !== m_ack) begin
				err_ack++;
				$display("[ERROR] %s: cfg_ack_o expected %b actual %b",
					test_name, m_ack, cfg_ack_o);
			end
			// Earlier word in the low half of each window.
			for (int i = 0; i < LANES; i++) begin
				win[i] = sign_ext(m_codes[i]);
				win[LANES + i] = sign_ext(codes_i[i]);
				bwin[i] = m_prev_bits[i];
				bwin[LANES + i] = m_sl_bits[i];
			end
			for (int l = 0; l < LANES; l++) begin
				acc = 0;
				for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
					acc += sign_ext(mc.weight[k][l]) * win[LANES + l - k];
				end
				acc = acc >>> mc.ffe_shift;
				if (acc > 127) begin
					acc = 127;
					sat_hi++;
				end else if (acc < -128) begin
					acc = -128;
					sat_lo++;
				end
				nxt_eq[l] = 8'(acc);
				nxt_raw[l] = sign_ext(m_eq[l]) >= sign_ext(mc.thresh[l]);
				past = 0;
				for (int k = 1; k < `DSP_EST_DEPTH; k++) begin
					if (bwin[LANES + l - k]) begin
						past += sign_ext(mc.est[k][l]);
					end else begin
						past -= sign_ext(mc.est[k][l]);
					end
				end
				pred_one = (past + sign_ext(mc.est[0][l])) >>> mc.mlsd_shift;
				pred_zero = (past - sign_ext(mc.est[0][l])) >>> mc.mlsd_shift;
				err_one = sign_ext(m_sl_codes[l]) - pred_one;
				err_zero = sign_ext(m_sl_codes[l]) - pred_zero;
				err_one = (err_one < 0) ? -err_one : err_one;
				err_zero = (err_zero < 0) ? -err_zero : err_zero;
				if (err_one < err_zero) begin
					nxt_chk[l] = 1'b1;
				end else if (err_zero < err_one) begin
					nxt_chk[l] = 1'b0;
				end else begin
					nxt_chk[l] = m_sl_bits[l];
				end
				if (nxt_chk[l] != m_sl_bits[l]) begin
					flips++;
				end
			end
			m_chk = nxt_chk;
			m_prev_bits = m_sl_bits;
			m_sl_bits = nxt_raw;
			m_sl_codes = m_codes;
			m_eq = nxt_eq;
			m_codes = codes_i;
			// New coefficients apply from the next edge on.
			if (cfg_req_i && !m_ack) begin
				m_ack = 1'b1;
				record_write(cfg_i);
			end else if (!cfg_req_i) begin
				m_ack = 1'b0;
			end
		end
	end

	initial begin
		rstb = 1'b0;
		codes_i = '0;
		cfg_req_i = 1'b0;
		cfg_i = '0;
		repeat (8) tick();
		rstb <= 1'b1;
		tick();
		if (cfg_ack_o !== 1'b0) begin
			err_misc++;
			$display("cfg_ack_o is not low after reset");
		end
		repeat (WORDS) tick();
		if (est_o !== '0) begin
			err_misc++;
			$display("[ERROR] %s: est_o expected %h actual %h", test_name, 32'h0, est_o);
		end
		if (checked_o !== 4'hf) begin
			err_misc++;
			$display("[ERROR] %s: checked_o expected %b actual %b",
				test_name, 4'hf, checked_o);
		end

		test_name = "ffe";
		for (int a = 0; a < `DSP_ADDR_THRESH; a++) begin
			cfg_write(5'(a), {8'h00, 8'(take_bits(8))});
		end
		ffe_sh = 4'(take_bits(2));
		cfg_write(5'(`DSP_ADDR_SHIFT), {ffe_sh, 4'h0, 8'h00});
		repeat (WORDS) tick();
		if (sat_hi == 0 || sat_lo == 0) begin
			err_misc++;
			$display("FFE output never reached both saturation limits");
		end

		test_name = "slicer";
		for (int a = 0; a < LANES; a++) begin
			cfg_write(5'(`DSP_ADDR_THRESH + a), {8'h00, 8'(take_bits(8))});
		end
		repeat (WORDS) tick();

		test_name = "mlsd";
		for (int a = `DSP_ADDR_EST; a < `DSP_ADDR_SHIFT; a++) begin
			cfg_write(5'(a), {8'h00, 8'(take_bits(8))});
		end
		cfg_write(5'(`DSP_ADDR_SHIFT), {ffe_sh, 4'(take_bits(2)), 8'h00});
		repeat (WORDS) tick();
		if (flips == 0) begin
			err_misc++;
			$display("No sequence decision differed from the raw bits");
		end

		test_name = "reconfig";
		repeat (30) cfg_write(5'(take_bits(5) % 29), 16'(take_bits(16)));
		repeat (WORDS / 2) tick();

		test_name = "out_of_map";
		for (int a = 29; a < 32; a++) begin
			cfg_write(5'(a), 16'(take_bits(16)));
		end
		repeat (WORDS) tick();

		$display("Errors: est_o %0d, checked_o %0d, cfg_ack_o %0d, other %0d",
			err_est, err_chk, err_ack, err_misc);
		if (err_est + err_chk + err_ack + err_misc == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule : dsp_backend_tb

`default_nettype wire
